/* build.f */
exu_pkg.sv
exu_fsm.sv
exu_datapath.sv
data_sram.sv
exu_top.sv
tb_exu.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_exu -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_exu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb_exu.sv */
`timescale 1ns/1ps

module tb_exu;

  import exu_pkg::*;

  localparam logic [31:0] SEED = 32'h5a257b27;
  localparam int N_ALU = 200;
  localparam int N_LOAD = 200;
  localparam int N_OOR = 40;
  localparam int N_TOTAL = N_ALU + N_LOAD + N_OOR;
  // each request is given 60 cycles, on top of the memory fill and the reset.
  localparam int TIMEOUT_CYCLES = 60 * N_TOTAL + (MEM_WORDS + 2) + 8;

  logic       clk;
  logic       rst;
  exu_req_t   req;
  logic       req_valid;
  logic       req_ready;
  exu_wb_t    wb;
  logic       wb_valid;
  logic       wb_ready;
  sram_fill_t fill;

  logic [31:0] seed;
  logic [31:0] shadow [MEM_WORDS];
  exu_wb_t     exp_q [$];
  int          cycles;

  exu_top u_exu_top (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .wb_o        (wb),
    .wb_valid_o  (wb_valid),
    .wb_ready_i  (wb_ready),
    .fill_i      (fill)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // the stimulus stream, only ever advanced by the main process.
  function automatic logic [31:0] rand32();
    seed = lcg_step(seed);
    return seed;
  endfunction

  // expected writeback for one request, built from the ALU and load rules.
  function automatic exu_wb_t ref_result(input exu_req_t q);
    exu_wb_t     res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  lane [5];
    logic [7:0]  b0;
    logic [7:0]  b1;
    res.rd = q.rd;
    res.err = 1'b0;
    res.data = '0;
    if (q.inst_type == INST_ALU) begin
      case (q.alu_op)
        ALU_ADD: res.data = q.src1 + q.src2;
        ALU_SUB: res.data = q.src1 - q.src2;
        ALU_AND: res.data = q.src1 & q.src2;
        ALU_OR:  res.data = q.src1 | q.src2;
        ALU_XOR: res.data = q.src1 ^ q.src2;
        ALU_SLL: res.data = q.src1 << q.src2[4:0];
        ALU_SRL: res.data = q.src1 >> q.src2[4:0];
        // with different signs the negative operand is the smaller one.
        ALU_SLT: begin
          if (q.src1[31] != q.src2[31]) res.data = {31'd0, q.src1[31]};
          else res.data = {31'd0, q.src1 < q.src2};
        end
        default: res.data = '0;
      endcase
    end else begin
      addr = q.src1 + q.src2;
      if (addr >= 32'(MEM_BYTES)) begin
        res.err = 1'b1;
      end else begin
        word = shadow[addr[9:2]];
        // a fifth lane of zeros feeds the upper byte of a halfword at offset 3.
        for (int k = 0; k < 4; k++) lane[k] = word[8*k +: 8];
        lane[4] = 8'h00;
        b0 = lane[{1'b0, addr[1:0]}];
        b1 = lane[{1'b0, addr[1:0]} + 3'd1];
        case (q.load_op)
          LD_W:    res.data = word;
          LD_H:    res.data = {{16{b1[7]}}, b1, b0};
          LD_HU:   res.data = {16'h0000, b1, b0};
          LD_B:    res.data = {{24{b0[7]}}, b0};
          LD_BU:   res.data = {24'h000000, b0};
          default: res.data = word;
        endcase
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    if (why != "") $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_wb(input string what, input exu_wb_t got, input exu_wb_t exp);
    if (got.rd !== exp.rd) begin
      $display("[FAIL] %s.rd got 0x%h expected 0x%h", what, got.rd, exp.rd);
      abort_run("");
    end
    if (got.data !== exp.data) begin
      $display("[FAIL] %s.data got 0x%h expected 0x%h", what, got.data, exp.data);
      abort_run("");
    end
    if (got.err !== exp.err) begin
      $display("[FAIL] %s.err got 0x%h expected 0x%h", what, got.err, exp.err);
      abort_run("");
    end
  endtask

  // writes every memory word once with random data and mirrors it.
  task automatic fill_memory();
    sram_fill_t f;
    for (int i = 0; i < MEM_WORDS; i++) begin
      f.we = 1'b1;
      f.addr = MEM_IDX_W'(i);
      f.wdata = rand32();
      shadow[i] = f.wdata;
      @(posedge clk);
      fill <= f;
    end
    @(posedge clk);
    fill <= '0;
  endtask

  // offers one request and holds it until the unit takes it.
  // ready is looked at on the falling edge, where it is settled.
  task automatic send_req(input exu_req_t q);
    @(posedge clk);
    req <= q;
    req_valid <= 1'b1;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    exp_q.push_back(ref_result(q));
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // writeback back-pressure, about one cycle in four held low.
  initial begin
    logic [31:0] st;
    st = SEED ^ 32'hffff_ffff;
    wb_ready <= 1'b0;
    forever begin
      @(posedge clk);
      st = lcg_step(st);
      wb_ready <= (st[31:30] != 2'b00);
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
        abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycles));
      end
    end
  end

  // checks each writeback transfer, and that a stalled result does not move.
  initial begin
    exu_wb_t prev_wb;
    exu_wb_t exp_wb;
    logic    stalled;
    stalled = 1'b0;
    prev_wb = '0;
    forever begin
      @(negedge clk);
      if (rst) begin
        if (req_ready && wb_valid) begin
          abort_run("req_ready_o and wb_valid_o were high in the same cycle");
        end
        if (wb_valid && stalled) check_wb("wb_o(stalled)", wb, prev_wb);
        if (wb_valid && wb_ready) begin
          if (exp_q.size() == 0) abort_run("a result was written back with no request pending");
          exp_wb = exp_q.pop_front();
          check_wb("wb_o", wb, exp_wb);
        end
        stalled = wb_valid && !wb_ready;
        prev_wb = wb;
      end
    end
  end

  initial begin
    exu_req_t    q;
    logic [31:0] addr;
    logic [31:0] r;
    logic [31:0] imm;
    rst <= 1'b0;
    req <= '0;
    req_valid <= 1'b0;
    fill <= '0;
    seed = SEED;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    fill_memory();
    @(negedge clk);
    if (!req_ready || wb_valid) begin
      abort_run("after reset the unit was not idle with ready high and no result offered");
    end
    // the op follows the loop index so that all eight ops appear.
    for (int i = 0; i < N_ALU; i++) begin
      q = '0;
      q.inst_type = INST_ALU;
      q.alu_op = alu_op_e'(i[2:0]);
      q.load_op = LD_W;
      q.rd = REG_ADDR_W'(rand32());
      q.src1 = rand32();
      q.src2 = rand32();
      send_req(q);
    end
    // every twenty loads walk through all load ops at all byte offsets.
    for (int i = 0; i < N_LOAD + N_OOR; i++) begin
      q = '0;
      q.inst_type = INST_LOAD;
      q.alu_op = ALU_ADD;
      q.load_op = load_op_e'(3'(i % 5));
      q.rd = REG_ADDR_W'(rand32());
      if (i < N_LOAD) begin
        addr = {22'd0, 8'(rand32()), 2'(i / 5)};
      end else if (i == N_LOAD) begin
        addr = 32'(MEM_BYTES);
      end else begin
        addr = rand32();
        if (addr < 32'(MEM_BYTES)) addr = addr + 32'(MEM_BYTES);
      end
      r = rand32();
      imm = {{20{r[11]}}, r[11:0]};
      q.src2 = imm;
      q.src1 = addr - imm;
      send_req(q);
    end
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    if (!wb_valid) begin
      $display("All checks passed");
      $finish;
    end else begin
      abort_run("a result was still offered after every request had been written back");
    end
  end

endmodule

/* exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input  logic                clk,
  input  logic                rst,
  input  exu_pkg::exu_req_t   req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output exu_pkg::exu_wb_t    wb_o,
  output logic                wb_valid_o,
  input  logic                wb_ready_i,
  input  exu_pkg::sram_fill_t fill_i
);

  import exu_pkg::*;

  // strobes from the controller to the datapath.
  logic    accept;
  logic    rdone;

  // read address channel between controller, datapath and memory.
  logic    arvalid;
  logic    arready;
  axi_ar_t ar;

  // read data channel back from the memory.
  logic    rvalid;
  logic    rready;
  axi_r_t  r;

  // the controller sequences the decode, read and writeback handshakes.
  exu_fsm u_exu_fsm (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid_i),
    .is_load_i   (req_i.inst_type == INST_LOAD),
    .req_ready_o (req_ready_o),
    .accept_o    (accept),
    .arvalid_o   (arvalid),
    .arready_i   (arready),
    .rvalid_i    (rvalid),
    .rready_o    (rready),
    .rdone_o     (rdone),
    .wb_valid_o  (wb_valid_o),
    .wb_ready_i  (wb_ready_i)
  );

  // the datapath computes ALU results and load addresses and shapes load data.
  exu_datapath u_exu_datapath (
    .clk      (clk),
    .rst      (rst),
    .req_i    (req_i),
    .accept_i (accept),
    .rdone_i  (rdone),
    .r_i      (r),
    .ar_o     (ar),
    .wb_o     (wb_o)
  );

  // the data memory answers the read channel and takes boot-time fills.
  data_sram u_data_sram (
    .clk       (clk),
    .rst       (rst),
    .fill_i    (fill_i),
    .arvalid_i (arvalid),
    .ar_i      (ar),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .r_o       (r)
  );

endmodule

/* data_sram.sv */
`timescale 1ns/1ps

module data_sram (
  input  logic                clk,
  input  logic                rst,
  input  exu_pkg::sram_fill_t fill_i,
  input  logic                arvalid_i,
  input  exu_pkg::axi_ar_t    ar_i,
  output logic                arready_o,
  output logic                rvalid_o,
  input  logic                rready_i,
  output exu_pkg::axi_r_t     r_o
);

  import exu_pkg::*;

  // word-wide storage.
  logic [XLEN-1:0] mem [MEM_WORDS];

  // read response register and its valid flag.
  axi_r_t          r_q;
  logic            rvalid_q;

  // handshake and address decode.
  logic            ar_fire;
  logic            in_range;
  logic [MEM_IDX_W-1:0] word_idx;

  // one read is held at a time, so a new address is taken only when none is pending.
  assign arready_o = !rvalid_q;
  assign ar_fire   = arvalid_i && arready_o;

  // the byte address is turned into a word index by dropping the two low bits.
  assign word_idx = ar_i.araddr[MEM_IDX_W+1:2];
  assign in_range = (ar_i.araddr < XLEN'(MEM_BYTES));

  // fill port for the boot loader. it writes one word per enabled edge.
  always_ff @(posedge clk) begin
    if (fill_i.we) begin
      mem[fill_i.addr] <= fill_i.wdata;
    end
  end

  // the read word is registered on the address handshake.
  // out-of-range reads give a slave error with zero data.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (in_range) begin
        r_q.rdata <= mem[word_idx];
        r_q.rresp <= RESP_OKAY;
      end else begin
        r_q.rdata <= '0;
        r_q.rresp <= RESP_SLVERR;
      end
    end
  end

  // rvalid rises the edge after the address handshake and falls once taken.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  assign rvalid_o = rvalid_q;
  assign r_o      = r_q;

  // every response belongs to an address the memory accepted the cycle before.
  a_rvalid_cause: assert property (
    @(posedge clk) disable iff (!rst)
    $rose(rvalid_o) |-> $past(arvalid_i && arready_o)
  ) else $error("rvalid rose without an address handshake");

endmodule

/* exu_datapath.sv */
`timescale 1ns/1ps

module exu_datapath (
  input  logic               clk,
  input  logic               rst,
  input  exu_pkg::exu_req_t  req_i,
  input  logic               accept_i,
  input  logic               rdone_i,
  input  exu_pkg::axi_r_t    r_i,
  output exu_pkg::axi_ar_t   ar_o,
  output exu_pkg::exu_wb_t   wb_o
);

  import exu_pkg::*;

  // operand latch for a load in flight.
  logic [XLEN-1:0] addr_q;
  load_op_e        load_op_q;

  // result register that feeds writeback.
  exu_wb_t         wb_q;

  // combinational results.
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] ld_addr;
  logic [XLEN-1:0] rd_shifted;
  logic [XLEN-1:0] ld_data;

  // the ALU works straight on the incoming operands.
  // this lets the result be registered on the accept edge itself.
  always_comb begin
    case (req_i.alu_op)
      ALU_ADD: alu_res = req_i.src1 + req_i.src2;
      ALU_SUB: alu_res = req_i.src1 - req_i.src2;
      ALU_AND: alu_res = req_i.src1 & req_i.src2;
      ALU_OR:  alu_res = req_i.src1 | req_i.src2;
      ALU_XOR: alu_res = req_i.src1 ^ req_i.src2;
      // shift amounts use only the low five bits of src2.
      ALU_SLL: alu_res = req_i.src1 << req_i.src2[4:0];
      ALU_SRL: alu_res = req_i.src1 >> req_i.src2[4:0];
      ALU_SLT: begin
        alu_res = {{(XLEN-1){1'b0}}, $signed(req_i.src1) < $signed(req_i.src2)};
      end
      default: alu_res = '0;
    endcase
  end

  // effective byte address of a load, base plus immediate.
  assign ld_addr = req_i.src1 + req_i.src2;

  // the low address bits pick the byte lane by shifting it down to bit 0.
  // a halfword at offset 3 thus gets zeros in its upper byte.
  assign rd_shifted = r_i.rdata >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (load_op_q)
      LD_W:    ld_data = r_i.rdata;
      LD_H:    ld_data = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
      LD_HU:   ld_data = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
      LD_B:    ld_data = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
      LD_BU:   ld_data = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
      default: ld_data = r_i.rdata;
    endcase
  end

  // the load address and op are held from accept until the data returns.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      addr_q    <= '0;
      load_op_q <= LD_W;
    end else if (accept_i && (req_i.inst_type == INST_LOAD)) begin
      addr_q    <= ld_addr;
      load_op_q <= req_i.load_op;
    end
  end

  // the result register is written once per instruction.
  // an ALU op writes it on accept, a load writes rd on accept and data on rdone.
  always_ff @(posedge clk) begin
    if (accept_i) begin
      wb_q.rd <= req_i.rd;
      if (req_i.inst_type == INST_ALU) begin
        wb_q.data <= alu_res;
        wb_q.err  <= 1'b0;
      end
    end else if (rdone_i) begin
      if (r_i.rresp == RESP_SLVERR) begin
        // an error response returns zero data with the err flag set.
        wb_q.data <= '0;
        wb_q.err  <= 1'b1;
      end else begin
        wb_q.data <= ld_data;
        wb_q.err  <= 1'b0;
      end
    end
  end

  assign ar_o.araddr = addr_q;
  assign wb_o        = wb_q;

  // a request is accepted only when the unit is idle, never during a read.
  a_no_accept_rdone: assert property (
    @(posedge clk) disable iff (!rst)
    !(accept_i && rdone_i)
  ) else $error("accept and rdone high together");

endmodule

/* exu_fsm.sv */
`timescale 1ns/1ps

module exu_fsm (
  input  logic clk,
  input  logic rst,
  input  logic req_valid_i,
  input  logic is_load_i,
  output logic req_ready_o,
  output logic accept_o,
  output logic arvalid_o,
  input  logic arready_i,
  input  logic rvalid_i,
  output logic rready_o,
  output logic rdone_o,
  output logic wb_valid_o,
  input  logic wb_ready_i
);

  import exu_pkg::*;

  exu_state_e state_q;
  exu_state_e state_d;

  // every handshake signal is a plain decode of the current state.
  // the unit takes a new instruction only when it holds nothing.
  assign req_ready_o = (state_q == S_IDLE);
  assign arvalid_o   = (state_q == S_WAIT_ARREADY);
  assign rready_o    = (state_q == S_WAIT_RVALID);
  assign wb_valid_o  = (state_q == S_WAIT_READY);

  // accept marks the decode transfer, so the datapath latches the request on it.
  assign accept_o = req_valid_i && req_ready_o;

  // rdone marks the read data transfer, where the load data is captured.
  assign rdone_o = rvalid_i && rready_o;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        // a load goes out on the read channel first.
        // an ALU result is already registered, so it is offered at once.
        if (req_valid_i) begin
          if (is_load_i) begin
            state_d = S_WAIT_ARREADY;
          end else begin
            state_d = S_WAIT_READY;
          end
        end
      end
      S_WAIT_ARREADY: begin
        if (arready_i) begin
          state_d = S_WAIT_RVALID;
        end
      end
      S_WAIT_RVALID: begin
        if (rvalid_i) begin
          state_d = S_WAIT_READY;
        end
      end
      S_WAIT_READY: begin
        // the result stays on offer until writeback takes it.
        if (wb_ready_i) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  // once raised, the address request is not withdrawn before the memory takes it.
  a_arvalid_hold: assert property (
    @(posedge clk) disable iff (!rst)
    arvalid_o && !arready_i |=> arvalid_o
  ) else $error("arvalid dropped before arready");

  // the writeback offer holds under back-pressure.
  a_wb_valid_hold: assert property (
    @(posedge clk) disable iff (!rst)
    wb_valid_o && !wb_ready_i |=> wb_valid_o
  ) else $error("wb_valid dropped before wb_ready");

  // read data comes back only while the controller waits for it, so none is lost.
  a_rvalid_expected: assert property (
    @(posedge clk) disable iff (!rst)
    rvalid_i |-> rready_o
  ) else $error("rvalid while no read was pending");

endmodule

/* exu_pkg.sv */
package exu_pkg;

  // data path and address width of the core.
  localparam int XLEN = 32;

  // depth of the data memory in 32-bit words.
  localparam int MEM_WORDS = 256;

  // width of the word index into the data memory.
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // first byte address past the end of the data memory.
  localparam int MEM_BYTES = 4 * MEM_WORDS;

  // width of a destination register index.
  localparam int REG_ADDR_W = 5;

  // instruction class as seen by the execute stage.
  typedef enum logic [0:0] {
    INST_ALU  = 1'b0,
    INST_LOAD = 1'b1
  } inst_type_e;

  // ALU operations, with slt doing a signed compare.
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  // load widths and extension modes.
  typedef enum logic [2:0] {
    LD_W  = 3'd0,
    LD_H  = 3'd1,
    LD_HU = 3'd2,
    LD_B  = 3'd3,
    LD_BU = 3'd4
  } load_op_e;

  // states of the execute controller.
  typedef enum logic [1:0] {
    S_IDLE         = 2'b00,
    S_WAIT_ARREADY = 2'b01,
    S_WAIT_RVALID  = 2'b10,
    S_WAIT_READY   = 2'b11
  } exu_state_e;

  // read response codes, using the AXI encoding.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // request from decode. for a load, src2 holds the sign-extended immediate.
  typedef struct packed {
    inst_type_e            inst_type;
    alu_op_e               alu_op;
    load_op_e              load_op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
  } exu_req_t;

  // result offered to writeback. err flags a load that got an error response.
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic                  err;
  } exu_wb_t;

  // read address channel payload.
  typedef struct packed {
    logic [XLEN-1:0] araddr;
  } axi_ar_t;

  // read data channel payload.
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    resp_e           rresp;
  } axi_r_t;

  // fill port of the data memory. addr is a word index.
  typedef struct packed {
    logic                 we;
    logic [MEM_IDX_W-1:0] addr;
    logic [XLEN-1:0]      wdata;
  } sram_fill_t;

endpackage
